//--- csr_index_gen.f
+incdir+include
hw/csr_index_pkg.sv
hw/mem_packet_pkg.sv
hw/csr_index_cfg_regs.sv
hw/csr_index_sequencer.sv
hw/request_fifo.sv
hw/csr_index_generator_top.sv
bench/csr_index_gen_chk.sv
bench/tb_csr_index_gen.sv

//--- Bender.yml
package:
  name: csr_index_gen

export_include_dirs:
  - include

sources:
  - files:
      - hw/csr_index_pkg.sv
      - hw/mem_packet_pkg.sv
      - hw/csr_index_cfg_regs.sv
      - hw/csr_index_sequencer.sv
      - hw/request_fifo.sv
      - hw/csr_index_generator_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/csr_index_gen_chk.sv
      - bench/tb_csr_index_gen.sv

//--- bench/tb_csr_index_gen.sv
`include "csr_index_gen_cfg.svh"

module tb_csr_index_gen;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'h6658;
    localparam int NUM_JOBS = 6;
    localparam int CYCLES_PER_REQUEST = 40;
    localparam int WATCHDOG_MARGIN = 2000;

    logic                         ap_clk;
    logic                         areset_generator;
    csr_index_pkg::index_cfg_t    cfg_in;
    logic                         cfg_req;
    logic                         cfg_ack;
    mem_packet_pkg::mem_request_t request_out;
    logic                         request_ready;
    logic                         done;

    logic [31:0]                  job_rng;
    logic [31:0]                  ready_rng;
    int                           ready_mode = 0;
    int                           watchdog_cycles = 0;
    mem_packet_pkg::mem_payload_t exp_q[$];
    csr_index_pkg::index_cfg_t    jobs[NUM_JOBS];

    csr_index_generator_top dut0 (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_in          (cfg_in),
        .cfg_req         (cfg_req),
        .cfg_ack         (cfg_ack),
        .request_out     (request_out),
        .request_ready   (request_ready),
        .done            (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #5 ap_clk = ~ap_clk;
    end

    // --------------------------------------------------
    // Random numbers and reference model
    // --------------------------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic csr_index_pkg::index_cfg_t make_job(
        input csr_index_pkg::shift_dir_e dir,
        input int unsigned               min_count
    );
        csr_index_pkg::index_cfg_t cfg;
        int unsigned               stride;
        int unsigned               start;
        int unsigned               stop;
        job_rng = lcg_next(job_rng);
        cfg.array_pointer = job_rng;
        job_rng = lcg_next(job_rng);
        stride = 1 + job_rng[31:29] % 5;
        start = job_rng[15:6];
        stop = start + stride * min_count + job_rng[21:16];
        cfg.stride = stride[`CSR_INDEX_W-1:0];
        cfg.index_start = start[`CSR_INDEX_W-1:0];
        cfg.index_end = stop[`CSR_INDEX_W-1:0];
        job_rng = lcg_next(job_rng);
        cfg.shift.direction = dir;
        cfg.shift.amount = job_rng[31 -: `CSR_SHIFT_W];
        return cfg;
    endfunction

    // Half open range, counted up by the stride
    function automatic int unsigned count_indices(input csr_index_pkg::index_cfg_t cfg);
        int unsigned idx;
        int unsigned n;
        n = 0;
        for (idx = cfg.index_start; idx < cfg.index_end; idx = idx + cfg.stride) begin
            n++;
        end
        return n;
    endfunction

    function automatic void build_expected(input csr_index_pkg::index_cfg_t cfg);
        mem_packet_pkg::mem_payload_t p;
        logic [`CSR_ADDR_W-1:0]       wide;
        int unsigned                  idx;
        for (idx = cfg.index_start; idx < cfg.index_end; idx = idx + cfg.stride) begin
            wide = idx;
            p.base = cfg.array_pointer;
            p.index = idx[`CSR_INDEX_W-1:0];
            if (cfg.shift.direction == csr_index_pkg::SHIFT_LEFT) begin
                p.offset = wide << cfg.shift.amount;
            end else begin
                p.offset = wide >> cfg.shift.amount;
            end
            exp_q.push_back(p);
        end
    endfunction

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_request(
        input mem_packet_pkg::mem_payload_t got,
        input mem_packet_pkg::mem_payload_t exp
    );
        if (got !== exp) begin
            abort_run($sformatf("FAIL request_out.payload got %h expected %h", got, exp));
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    // --------------------------------------------------
    // Host handshake
    // --------------------------------------------------
    task automatic raise_request(input csr_index_pkg::index_cfg_t cfg);
        build_expected(cfg);
        @(posedge ap_clk);
        #1;
        cfg_in = cfg;
        cfg_req = 1'b1;
    endtask

    task automatic wait_ack();
        do @(negedge ap_clk); while (!cfg_ack);
    endtask

    // Ack has to hold while req is high, then drop one cycle after req
    // The new job clears done in the first two cycles
    task automatic finish_handshake();
        repeat (2) begin
            @(negedge ap_clk);
            compare_bit("cfg_ack", cfg_ack, 1'b1);
            compare_bit("done", done, 1'b0);
        end
        @(posedge ap_clk);
        #1;
        cfg_req = 1'b0;
        @(posedge ap_clk);
        @(negedge ap_clk);
        compare_bit("cfg_ack", cfg_ack, 1'b0);
    endtask

    task automatic send_job(input csr_index_pkg::index_cfg_t cfg);
        raise_request(cfg);
        wait_ack();
        finish_handshake();
    endtask

    task automatic wait_done();
        do @(negedge ap_clk); while (!done);
    endtask

    task automatic drain_requests();
        while (exp_q.size() != 0) begin
            @(negedge ap_clk);
        end
    endtask

    // Consumer side, mode 2 gives long stalls that fill the FIFO
    initial begin
        int  left;
        logic burst_on;
        request_ready = 1'b0;
        ready_rng = ~SEED;
        left = 0;
        burst_on = 1'b0;
        forever begin
            @(posedge ap_clk);
            #1;
            ready_rng = lcg_next(ready_rng);
            case (ready_mode)
                0: request_ready = 1'b1;
                1: request_ready = (ready_rng[31:30] != 2'b00);
                default: begin
                    if (left == 0) begin
                        burst_on = !burst_on;
                        left = burst_on ? 1 + ready_rng[27:24] : 12 + ready_rng[29:25];
                    end
                    left--;
                    request_ready = burst_on;
                end
            endcase
        end
    end

    // Popped requests against the model
    always @(negedge ap_clk) begin
        if (!areset_generator && request_out.valid && request_ready) begin
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected request with index %h, none was due",
                                    request_out.payload.index));
            end else begin
                compare_request(request_out.payload, exp_q.pop_front());
            end
        end
    end

    initial begin
        wait (dut0.chk0.assert_failures != 0);
        abort_run("A protocol assertion on the DUT failed");
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge ap_clk);
        abort_run($sformatf("Timeout after %0d cycles, %0d requests never arrived",
                            watchdog_cycles, exp_q.size()));
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int unsigned total;
        logic        done_seen;
        areset_generator = 1'b1;
        cfg_in = '0;
        cfg_req = 1'b0;
        job_rng = SEED;
        jobs[0] = make_job(csr_index_pkg::SHIFT_LEFT, 10);
        jobs[1] = make_job(csr_index_pkg::SHIFT_RIGHT, 10);
        jobs[2] = make_job(csr_index_pkg::SHIFT_LEFT, 60);
        jobs[3] = make_job(csr_index_pkg::SHIFT_RIGHT, 1);
        // Start above end, nothing to emit
        jobs[3].index_end = jobs[3].index_start;
        jobs[3].index_start = jobs[3].index_start + 16'd3;
        jobs[4] = make_job(csr_index_pkg::SHIFT_RIGHT, 50);
        jobs[5] = make_job(csr_index_pkg::SHIFT_LEFT, 10);
        total = 0;
        foreach (jobs[i]) begin
            total += count_indices(jobs[i]);
        end
        watchdog_cycles = total * CYCLES_PER_REQUEST + WATCHDOG_MARGIN;

        repeat (3) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        @(negedge ap_clk);
        compare_bit("cfg_ack", cfg_ack, 1'b0);
        compare_bit("done", done, 1'b0);
        compare_bit("request_out.valid", request_out.valid, 1'b0);

        for (int j = 0; j < 3; j++) begin
            ready_mode = j;
            send_job(jobs[j]);
            wait_done();
            drain_requests();
        end

        // Empty job
        ready_mode = 0;
        send_job(jobs[3]);
        wait_done();
        compare_bit("request_out.valid", request_out.valid, 1'b0);
        repeat (5) @(negedge ap_clk);

        // Second request while the first job runs
        ready_mode = 2;
        send_job(jobs[4]);
        raise_request(jobs[5]);
        done_seen = 1'b0;
        do begin
            @(negedge ap_clk);
            if (cfg_ack && !done_seen) begin
                abort_run("cfg_ack rose before the running job reached done");
            end
            if (done) begin
                done_seen = 1'b1;
            end
        end while (!cfg_ack);
        finish_handshake();
        wait_done();
        drain_requests();
        repeat (5) @(negedge ap_clk);

        if (dut0.chk0.assert_failures == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "%0d assertion failures at the end of the run",
                   dut0.chk0.assert_failures);
        end
    end

endmodule

//--- bench/csr_index_gen_chk.sv
module csr_index_gen_chk (
    input logic                         ap_clk,
    input logic                         areset_generator,
    input logic                         cfg_req,
    input logic                         cfg_ack,
    input mem_packet_pkg::mem_request_t request_out,
    input logic                         request_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read by the testbench to stop the run
    int assert_failures = 0;

    // --------------------------------------------------
    // Host handshake
    // --------------------------------------------------
    ack_rise_needs_req: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else begin
        assert_failures++;
        $error("cfg_ack rose while cfg_req was low");
    end

    ack_fall_after_req: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        $fell(cfg_ack) |-> !$past(cfg_req)
    ) else begin
        assert_failures++;
        $error("cfg_ack fell while cfg_req was still high");
    end

    // --------------------------------------------------
    // Request output
    // --------------------------------------------------
    valid_low_after_reset: assert property (
        @(posedge ap_clk)
        $fell(areset_generator) |-> !request_out.valid
    ) else begin
        assert_failures++;
        $error("request_out.valid high in the first cycle after reset");
    end

    // Head must hold while the consumer stalls
    request_stable_when_stalled: assert property (
        @(posedge ap_clk) disable iff (areset_generator)
        (request_out.valid && !request_ready) |=> $stable(request_out)
    ) else begin
        assert_failures++;
        $error("request_out changed while valid was high and ready low");
    end

endmodule

bind csr_index_generator_top csr_index_gen_chk chk0 (
    .ap_clk          (ap_clk),
    .areset_generator(areset_generator),
    .cfg_req         (cfg_req),
    .cfg_ack         (cfg_ack),
    .request_out     (request_out),
    .request_ready   (request_ready)
);

//--- hw/csr_index_generator_top.sv
`include "csr_index_gen_cfg.svh"

module csr_index_generator_top (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  csr_index_pkg::index_cfg_t    cfg_in,
    input  logic                         cfg_req,
    output logic                         cfg_ack,
    output mem_packet_pkg::mem_request_t request_out,
    input  logic                         request_ready,
    output logic                         done
);

    csr_index_pkg::index_cfg_t    job_cfg;
    logic                         job_start;
    logic                         busy;
    logic                         prog_full;
    logic                         push;
    mem_packet_pkg::mem_payload_t push_data;

    // --------------------------------------------------
    // Host configuration registers
    // --------------------------------------------------
    csr_index_cfg_regs u_cfg_regs (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .cfg_in          (cfg_in),
        .cfg_req         (cfg_req),
        .cfg_ack         (cfg_ack),
        .busy            (busy),
        .job_cfg         (job_cfg),
        .job_start       (job_start)
    );

    // --------------------------------------------------
    // Index sequencer
    // --------------------------------------------------
    csr_index_sequencer u_sequencer (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .job_cfg         (job_cfg),
        .job_start       (job_start),
        .busy            (busy),
        .prog_full       (prog_full),
        .push            (push),
        .push_data       (push_data),
        .done            (done)
    );

    // Request FIFO towards the consumer
    request_fifo u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (push),
        .push_data       (push_data),
        .prog_full       (prog_full),
        .request_ready   (request_ready),
        .request_out     (request_out)
    );

endmodule

//--- hw/request_fifo.sv
`include "csr_index_gen_cfg.svh"

module request_fifo (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         push,
    input  mem_packet_pkg::mem_payload_t push_data,
    output logic                         prog_full,
    input  logic                         request_ready,
    output mem_packet_pkg::mem_request_t request_out
);

    localparam int DEPTH = `CSR_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    mem_packet_pkg::mem_payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill_count;
    logic             empty;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    // --------------------------------------------------
    // Status and strobes
    // --------------------------------------------------
    assign empty     = (fill_count == '0);
    assign full      = (fill_count == DEPTH[PTR_W:0]);
    assign prog_full = (fill_count >= `CSR_FIFO_PROG_THRESH);
    assign wr_en     = push && !full;
    assign rd_en     = request_ready && !empty;

    // --------------------------------------------------
    // Pointers and fill count
    // --------------------------------------------------
    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill_count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   fill_count <= fill_count + 1'b1;
                2'b01:   fill_count <= fill_count - 1'b1;
                default: fill_count <= fill_count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // First word fall through, head shown while not empty
    assign request_out.valid   = !empty;
    assign request_out.payload = mem[rd_ptr];

endmodule

//--- hw/csr_index_sequencer.sv
`include "csr_index_gen_cfg.svh"

module csr_index_sequencer (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  csr_index_pkg::index_cfg_t    job_cfg,
    input  logic                         job_start,
    output logic                         busy,
    input  logic                         prog_full,
    output logic                         push,
    output mem_packet_pkg::mem_payload_t push_data,
    output logic                         done
);

    csr_index_pkg::gen_state_e state;
    csr_index_pkg::gen_state_e next_state;

    logic [`CSR_INDEX_W-1:0] index_count;
    // One extra bit catches counter wrap on large strides
    logic [`CSR_INDEX_W:0]   index_next;
    logic                    index_last;
    logic                    index_valid;
    logic                    write_en;
    logic [`CSR_ADDR_W-1:0]  index_wide;

    // --------------------------------------------------
    // Index counter
    // --------------------------------------------------
    assign index_next  = {1'b0, index_count} + {1'b0, job_cfg.stride};
    assign index_valid = index_count < job_cfg.index_end;
    assign index_last  = index_next[`CSR_INDEX_W]
                      || (index_next[`CSR_INDEX_W-1:0] >= job_cfg.index_end);
    assign write_en    = (state == csr_index_pkg::BUSY) && !prog_full && index_valid;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            index_count <= '0;
        end else if (state == csr_index_pkg::START) begin
            index_count <= job_cfg.index_start;
        end else if (write_en) begin
            index_count <= index_next[`CSR_INDEX_W-1:0];
        end
    end

    // --------------------------------------------------
    // State machine
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= csr_index_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            csr_index_pkg::IDLE: begin
                if (job_start) begin
                    next_state = csr_index_pkg::START;
                end
            end
            csr_index_pkg::START: begin
                next_state = csr_index_pkg::BUSY;
            end
            csr_index_pkg::BUSY: begin
                // Empty range ends here without a write
                if (!index_valid) begin
                    next_state = csr_index_pkg::DONE;
                end else if (prog_full) begin
                    next_state = csr_index_pkg::PAUSE;
                end else if (index_last) begin
                    next_state = csr_index_pkg::DONE;
                end
            end
            csr_index_pkg::PAUSE: begin
                if (!prog_full) begin
                    next_state = csr_index_pkg::BUSY;
                end
            end
            csr_index_pkg::DONE: begin
                if (job_start) begin
                    next_state = csr_index_pkg::START;
                end
            end
            default: begin
                next_state = csr_index_pkg::IDLE;
            end
        endcase
    end

    assign busy = (state == csr_index_pkg::START)
               || (state == csr_index_pkg::BUSY)
               || (state == csr_index_pkg::PAUSE);
    assign done = (state == csr_index_pkg::DONE);

    // --------------------------------------------------
    // Request formatting
    // --------------------------------------------------
    assign index_wide = {{(`CSR_ADDR_W-`CSR_INDEX_W){1'b0}}, index_count};

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            push <= 1'b0;
        end else begin
            push <= write_en;
        end
    end

    // Registered write, lands in the FIFO one cycle later
    always_ff @(posedge ap_clk) begin
        push_data.base  <= job_cfg.array_pointer;
        push_data.index <= index_count;
        if (job_cfg.shift.direction == csr_index_pkg::SHIFT_LEFT) begin
            push_data.offset <= index_wide << job_cfg.shift.amount;
        end else begin
            push_data.offset <= index_wide >> job_cfg.shift.amount;
        end
    end

endmodule

//--- hw/csr_index_cfg_regs.sv
`include "csr_index_gen_cfg.svh"

module csr_index_cfg_regs (
    input  logic                      ap_clk,
    input  logic                      areset_generator,
    input  csr_index_pkg::index_cfg_t cfg_in,
    input  logic                      cfg_req,
    output logic                      cfg_ack,
    input  logic                      busy,
    output csr_index_pkg::index_cfg_t job_cfg,
    output logic                      job_start
);

    logic accept;

    // --------------------------------------------------
    // Four-phase handshake
    // --------------------------------------------------
    // New request only once the previous ack has dropped,
    // and never while a job is running
    assign accept = cfg_req && !cfg_ack && !busy;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            cfg_ack   <= 1'b0;
            job_start <= 1'b0;
        end else begin
            job_start <= accept;
            if (accept) begin
                cfg_ack <= 1'b1;
            end else if (!cfg_req) begin
                // Return to zero phase
                cfg_ack <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Job configuration register
    // --------------------------------------------------
    // Captured on the same edge that raises ack
    always_ff @(posedge ap_clk) begin
        if (accept) begin
            job_cfg <= cfg_in;
        end
    end

endmodule

//--- hw/mem_packet_pkg.sv
`include "csr_index_gen_cfg.svh"

package mem_packet_pkg;

    // --------------------------------------------------
    // Memory request payload
    // --------------------------------------------------
    // Base is the array pointer of the job
    // Offset is the shifted index, index is the raw count
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]  base;
        logic [`CSR_ADDR_W-1:0]  offset;
        logic [`CSR_INDEX_W-1:0] index;
    } mem_payload_t;

    // --------------------------------------------------
    // Request as seen by the consumer
    // --------------------------------------------------
    typedef struct packed {
        logic         valid;
        mem_payload_t payload;
    } mem_request_t;

endpackage

//--- hw/csr_index_pkg.sv
`include "csr_index_gen_cfg.svh"

package csr_index_pkg;

    // --------------------------------------------------
    // Offset shift setting
    // --------------------------------------------------
    typedef enum logic {
        SHIFT_RIGHT = 1'b0,
        SHIFT_LEFT  = 1'b1
    } shift_dir_e;

    typedef struct packed {
        shift_dir_e              direction;
        logic [`CSR_SHIFT_W-1:0] amount;
    } shift_cfg_t;

    // --------------------------------------------------
    // Job configuration written by the host
    // --------------------------------------------------
    // Index range is half open, end is never emitted
    typedef struct packed {
        logic [`CSR_ADDR_W-1:0]  array_pointer;
        logic [`CSR_INDEX_W-1:0] index_start;
        logic [`CSR_INDEX_W-1:0] index_end;
        logic [`CSR_INDEX_W-1:0] stride;
        shift_cfg_t              shift;
    } index_cfg_t;

    // --------------------------------------------------
    // Sequencer states
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        // Counter load
        START = 3'd1,
        // One write per cycle
        BUSY  = 3'd2,
        // FIFO above threshold
        PAUSE = 3'd3,
        DONE  = 3'd4
    } gen_state_e;

endpackage

//--- include/csr_index_gen_cfg.svh
`ifndef CSR_INDEX_GEN_CFG_SVH
`define CSR_INDEX_GEN_CFG_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
// Vertex index as counted by the sequencer
`define CSR_INDEX_W 16
// Array base address and request offset
`define CSR_ADDR_W 32
`define CSR_SHIFT_W 3

// --------------------------------------------------
// Request FIFO sizing
// --------------------------------------------------
`define CSR_FIFO_DEPTH 16
// Leaves headroom for the write still in flight
`define CSR_FIFO_PROG_THRESH 8

`endif
